// ==== verilog/flight_pkg.sv ====
package flight_pkg;

	// receiver and fixed-point formats
	localparam int REC_VAL_BIT_WIDTH = 8;
	localparam int RATE_BIT_WIDTH = 16;
	localparam int FIXED_POINT_SHIFT = 4;
	// wide enough for mapped values and mixer sums
	localparam int OPS_BIT_WIDTH = 18;
	localparam int RATE_SAT_MAX = (1 << (RATE_BIT_WIDTH - 1)) - 1;

	// stick 0..250 -> +-31.25 deg once scaled by 4
	localparam int MAPPING_SUBS = 500;

	// proportional gains, multiplier then right shift
	localparam int ROLL_K_P = 5;
	localparam int ROLL_K_P_SHIFT = 2;
	localparam int PITCH_K_P = 5;
	localparam int PITCH_K_P_SHIFT = 2;
	localparam int YAW_STICK_K_P = 1;
	localparam int YAW_STICK_K_P_SHIFT = 0;
	localparam int YAW_ACC_K_P = 3;
	localparam int YAW_ACC_K_P_SHIFT = 1;
	localparam int THROTTLE_K_P = 1;
	localparam int THROTTLE_K_P_SHIFT = 0;

	// limits in Q12.4
	localparam int THROTTLE_MAX = 250 << FIXED_POINT_SHIFT;
	localparam int AXIS_RATE_MAX = 200 << FIXED_POINT_SHIFT;
	localparam int MOTOR_MAX = 4000;

	// heading integration
	localparam int YAW_TICK_SHIFT = 3;
	localparam int HEADING_HALF_TURN = 180 << FIXED_POINT_SHIFT;

	// one-hot controller states
	typedef enum logic [4:0] {
		WAITING  = 5'b00001,
		MAPPING  = 5'b00010,
		SCALING  = 5'b00100,
		LIMITING = 5'b01000,
		COMPLETE = 5'b10000
	} ctrl_state_t;

	// stick value times 4 minus 500, centred stick gives zero
	function automatic logic signed [OPS_BIT_WIDTH-1:0] map_stick(
		input logic [REC_VAL_BIT_WIDTH-1:0] stick
	);
		return $signed({{(OPS_BIT_WIDTH - REC_VAL_BIT_WIDTH - 2){1'b0}}, stick, 2'b00})
			- OPS_BIT_WIDTH'(MAPPING_SUBS);
	endfunction

endpackage

// ==== verilog/rate_cmd_if.sv ====
`timescale 1ns/1ps

interface rate_cmd_if import flight_pkg::*; ();

	// Q12.4 rate commands from the angle controller
	logic signed [RATE_BIT_WIDTH-1:0] throttle_rate;
	logic signed [RATE_BIT_WIDTH-1:0] yaw_rate;
	logic signed [RATE_BIT_WIDTH-1:0] pitch_rate;
	logic signed [RATE_BIT_WIDTH-1:0] roll_rate;
	// one-cycle pulse, rates hold until the next update
	logic valid;

	modport source (
		output throttle_rate, yaw_rate, pitch_rate, roll_rate,
		output valid
	);

	modport sink (
		input throttle_rate, yaw_rate, pitch_rate, roll_rate,
		input valid
	);

endinterface

// ==== verilog/yaw_accumulator.sv ====
`timescale 1ns/1ps

module yaw_accumulator import flight_pkg::*; (
	input  logic                             us_clk,
	input  logic                             resetn,
	input  logic                             start_signal,
	input  logic [REC_VAL_BIT_WIDTH-1:0]     yaw_target,
	input  logic signed [RATE_BIT_WIDTH-1:0] yaw_actual,
	output logic signed [RATE_BIT_WIDTH-1:0] heading_error
);

	logic signed [RATE_BIT_WIDTH-1:0] heading;
	logic signed [RATE_BIT_WIDTH-1:0] next_heading;
	logic signed [OPS_BIT_WIDTH-1:0]  yaw_step;
	logic signed [OPS_BIT_WIDTH-1:0]  error_raw;

	// fold an angle back into -180..180 deg
	// one correction is enough for sums of two in-range angles
	function automatic logic signed [RATE_BIT_WIDTH-1:0] wrap_half_turn(
		input logic signed [OPS_BIT_WIDTH-1:0] angle
	);
		logic signed [OPS_BIT_WIDTH-1:0] wrapped;
		wrapped = angle;
		if (angle >= HEADING_HALF_TURN)
			wrapped = OPS_BIT_WIDTH'(angle - 2 * HEADING_HALF_TURN);
		else if (angle < -HEADING_HALF_TURN)
			wrapped = OPS_BIT_WIDTH'(angle + 2 * HEADING_HALF_TURN);
		return $signed(wrapped[RATE_BIT_WIDTH-1:0]);
	endfunction

	// stick rate per tick, divided by 8
	assign yaw_step = map_stick(yaw_target) >>> YAW_TICK_SHIFT;

	assign next_heading = wrap_half_turn(OPS_BIT_WIDTH'(heading) + yaw_step);

	// error against the IMU yaw of the same edge
	assign error_raw = OPS_BIT_WIDTH'(next_heading) - OPS_BIT_WIDTH'(yaw_actual);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			heading       <= '0;
			heading_error <= '0;
		end else if (start_signal) begin
			heading       <= next_heading;
			// short way round
			heading_error <= wrap_half_turn(error_raw);
		end
	end

endmodule

// ==== verilog/angle_controller.sv ====
`timescale 1ns/1ps

module angle_controller import flight_pkg::*; (
	input  logic                             us_clk,
	input  logic                             resetn,
	input  logic                             start_signal,
	input  logic [REC_VAL_BIT_WIDTH-1:0]     throttle_target,
	input  logic [REC_VAL_BIT_WIDTH-1:0]     yaw_target,
	input  logic [REC_VAL_BIT_WIDTH-1:0]     pitch_target,
	input  logic [REC_VAL_BIT_WIDTH-1:0]     roll_target,
	input  logic signed [RATE_BIT_WIDTH-1:0] heading_error,
	input  logic signed [RATE_BIT_WIDTH-1:0] pitch_actual,
	input  logic signed [RATE_BIT_WIDTH-1:0] roll_actual,
	input  logic                             switch_a,
	input  logic                             yaac_enable_n,
	rate_cmd_if.source                       rate_cmd,
	output logic                             active_signal,
	output logic signed [RATE_BIT_WIDTH-1:0] pitch_angle_error,
	output logic signed [RATE_BIT_WIDTH-1:0] roll_angle_error,
	output logic signed [RATE_BIT_WIDTH-1:0] yaw_angle_error
);

	ctrl_state_t state, next_state;
	logic start_flag;

	// inputs captured when leaving WAITING
	logic [REC_VAL_BIT_WIDTH-1:0]     throttle_cap, yaw_cap, pitch_cap, roll_cap;
	logic signed [RATE_BIT_WIDTH-1:0] heading_cap, pitch_act_cap, roll_act_cap;
	logic                             switch_cap, yaac_n_cap;
	logic signed [OPS_BIT_WIDTH-1:0]  stick_mult;

	logic signed [OPS_BIT_WIDTH-1:0]  mapped_throttle, mapped_yaw, mapped_pitch, mapped_roll;
	logic signed [RATE_BIT_WIDTH-1:0] scaled_throttle, scaled_yaw, scaled_pitch, scaled_roll;

	function automatic logic signed [RATE_BIT_WIDTH-1:0] sat_rate(
		input logic signed [31:0] val
	);
		if (val > RATE_SAT_MAX)
			return RATE_BIT_WIDTH'(RATE_SAT_MAX);
		else if (val < -RATE_SAT_MAX)
			return RATE_BIT_WIDTH'(-RATE_SAT_MAX);
		return val[RATE_BIT_WIDTH-1:0];
	endfunction

	// (val * k_mult) >>> k_shift, widened first so nothing overflows
	function automatic logic signed [RATE_BIT_WIDTH-1:0] scale_axis(
		input logic signed [OPS_BIT_WIDTH-1:0] val,
		input int                              k_mult,
		input int                              k_shift
	);
		logic signed [31:0] product;
		product = (32'(val) * k_mult) >>> k_shift;
		return sat_rate(product);
	endfunction

	function automatic logic signed [RATE_BIT_WIDTH-1:0] clamp_rate(
		input logic signed [RATE_BIT_WIDTH-1:0] val,
		input int                               lo,
		input int                               hi
	);
		if (val > hi)
			return RATE_BIT_WIDTH'(hi);
		else if (val < lo)
			return RATE_BIT_WIDTH'(lo);
		return val;
	endfunction

	// doubled stick range with switch A
	assign stick_mult = switch_cap ? OPS_BIT_WIDTH'(2) : OPS_BIT_WIDTH'(1);

	// pulse only counts when idle, nothing is queued
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			start_flag <= 1'b0;
		else
			start_flag <= start_signal && (state == WAITING) && !start_flag;
	end

	always_comb begin
		next_state = state;
		unique case (state)
			WAITING:  if (start_flag) next_state = MAPPING;
			MAPPING:  next_state = SCALING;
			SCALING:  next_state = LIMITING;
			LIMITING: next_state = COMPLETE;
			COMPLETE: next_state = WAITING;
			default:  next_state = WAITING;
		endcase
	end

	// datapath registers
	always_ff @(posedge us_clk) begin
		case (state)
			WAITING: begin
				if (start_flag) begin
					throttle_cap  <= throttle_target;
					yaw_cap       <= yaw_target;
					pitch_cap     <= pitch_target;
					roll_cap      <= roll_target;
					heading_cap   <= heading_error;
					pitch_act_cap <= pitch_actual;
					roll_act_cap  <= roll_actual;
					switch_cap    <= switch_a;
					yaac_n_cap    <= yaac_enable_n;
				end
			end
			MAPPING: begin
				// throttle stick x16, 0..250 deg/s
				mapped_throttle <= $signed({{(OPS_BIT_WIDTH - REC_VAL_BIT_WIDTH
					- FIXED_POINT_SHIFT){1'b0}}, throttle_cap, {FIXED_POINT_SHIFT{1'b0}}});
				mapped_pitch <= map_stick(pitch_cap) * stick_mult - OPS_BIT_WIDTH'(pitch_act_cap);
				// IMU roll is sign-flipped
				mapped_roll  <= map_stick(roll_cap) * stick_mult + OPS_BIT_WIDTH'(roll_act_cap);
				mapped_yaw   <= yaac_n_cap ? map_stick(yaw_cap) : OPS_BIT_WIDTH'(heading_cap);
			end
			SCALING: begin
				scaled_throttle <= scale_axis(mapped_throttle, THROTTLE_K_P, THROTTLE_K_P_SHIFT);
				scaled_pitch    <= scale_axis(mapped_pitch, PITCH_K_P, PITCH_K_P_SHIFT);
				scaled_roll     <= scale_axis(mapped_roll, ROLL_K_P, ROLL_K_P_SHIFT);
				if (yaac_n_cap)
					scaled_yaw <= scale_axis(mapped_yaw, YAW_STICK_K_P, YAW_STICK_K_P_SHIFT);
				else
					scaled_yaw <= scale_axis(mapped_yaw, YAW_ACC_K_P, YAW_ACC_K_P_SHIFT);
			end
			default: ;
		endcase
	end

	// control and outputs
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state                  <= WAITING;
			active_signal          <= 1'b0;
			rate_cmd.valid         <= 1'b0;
			rate_cmd.throttle_rate <= '0;
			rate_cmd.yaw_rate      <= '0;
			rate_cmd.pitch_rate    <= '0;
			rate_cmd.roll_rate     <= '0;
			pitch_angle_error      <= '0;
			roll_angle_error       <= '0;
			yaw_angle_error        <= '0;
		end else begin
			state          <= next_state;
			active_signal  <= (state == MAPPING) || (state == SCALING) || (state == LIMITING);
			// valid doubles as the complete pulse
			rate_cmd.valid <= (state == COMPLETE);
			if (state == LIMITING) begin
				rate_cmd.throttle_rate <= clamp_rate(scaled_throttle, 0, THROTTLE_MAX);
				rate_cmd.yaw_rate   <= clamp_rate(scaled_yaw, -AXIS_RATE_MAX, AXIS_RATE_MAX);
				rate_cmd.pitch_rate <= clamp_rate(scaled_pitch, -AXIS_RATE_MAX, AXIS_RATE_MAX);
				rate_cmd.roll_rate  <= clamp_rate(scaled_roll, -AXIS_RATE_MAX, AXIS_RATE_MAX);
				pitch_angle_error   <= sat_rate(32'(mapped_pitch));
				roll_angle_error    <= sat_rate(32'(mapped_roll));
				yaw_angle_error     <= sat_rate(32'(mapped_yaw));
			end
		end
	end

endmodule

// ==== verilog/motor_mixer.sv ====
`timescale 1ns/1ps

module motor_mixer import flight_pkg::*; (
	input  logic                      us_clk,
	input  logic                      resetn,
	rate_cmd_if.sink                  rate_cmd,
	output logic [RATE_BIT_WIDTH-1:0] motor_0,
	output logic [RATE_BIT_WIDTH-1:0] motor_1,
	output logic [RATE_BIT_WIDTH-1:0] motor_2,
	output logic [RATE_BIT_WIDTH-1:0] motor_3,
	output logic                      motors_valid
);

	logic signed [OPS_BIT_WIDTH-1:0] throttle, pitch, roll, yaw;
	logic signed [OPS_BIT_WIDTH-1:0] sum_0, sum_1, sum_2, sum_3;

	// motors never spin backwards or past full scale
	function automatic logic [RATE_BIT_WIDTH-1:0] clamp_motor(
		input logic signed [OPS_BIT_WIDTH-1:0] sum
	);
		if (sum < 0)
			return '0;
		else if (sum > MOTOR_MAX)
			return RATE_BIT_WIDTH'(MOTOR_MAX);
		return sum[RATE_BIT_WIDTH-1:0];
	endfunction

	assign throttle = OPS_BIT_WIDTH'(rate_cmd.throttle_rate);
	assign pitch    = OPS_BIT_WIDTH'(rate_cmd.pitch_rate);
	assign roll     = OPS_BIT_WIDTH'(rate_cmd.roll_rate);
	assign yaw      = OPS_BIT_WIDTH'(rate_cmd.yaw_rate);

	// X frame, diagonal pairs share the yaw sign
	// front left
	assign sum_0 = throttle + pitch + roll - yaw;
	// front right
	assign sum_1 = throttle + pitch - roll + yaw;
	// rear left
	assign sum_2 = throttle - pitch + roll + yaw;
	// rear right
	assign sum_3 = throttle - pitch - roll - yaw;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			motor_0      <= '0;
			motor_1      <= '0;
			motor_2      <= '0;
			motor_3      <= '0;
			motors_valid <= 1'b0;
		end else begin
			motors_valid <= rate_cmd.valid;
			if (rate_cmd.valid) begin
				motor_0 <= clamp_motor(sum_0);
				motor_1 <= clamp_motor(sum_1);
				motor_2 <= clamp_motor(sum_2);
				motor_3 <= clamp_motor(sum_3);
			end
		end
	end

endmodule

// ==== verilog/attitude_top.sv ====
`timescale 1ns/1ps

module attitude_top import flight_pkg::*; (
	input  logic                             us_clk,
	input  logic                             resetn,
	input  logic                             start_signal,
	input  logic [REC_VAL_BIT_WIDTH-1:0]     throttle_target,
	input  logic [REC_VAL_BIT_WIDTH-1:0]     yaw_target,
	input  logic [REC_VAL_BIT_WIDTH-1:0]     pitch_target,
	input  logic [REC_VAL_BIT_WIDTH-1:0]     roll_target,
	input  logic signed [RATE_BIT_WIDTH-1:0] yaw_actual,
	input  logic signed [RATE_BIT_WIDTH-1:0] pitch_actual,
	input  logic signed [RATE_BIT_WIDTH-1:0] roll_actual,
	input  logic                             switch_a,
	input  logic                             yaac_enable_n,
	output logic [RATE_BIT_WIDTH-1:0]        motor_0,
	output logic [RATE_BIT_WIDTH-1:0]        motor_1,
	output logic [RATE_BIT_WIDTH-1:0]        motor_2,
	output logic [RATE_BIT_WIDTH-1:0]        motor_3,
	output logic                             motors_valid,
	output logic                             active_signal,
	output logic signed [RATE_BIT_WIDTH-1:0] pitch_angle_error,
	output logic signed [RATE_BIT_WIDTH-1:0] roll_angle_error,
	output logic signed [RATE_BIT_WIDTH-1:0] yaw_angle_error
);

	logic signed [RATE_BIT_WIDTH-1:0] heading_error;

	rate_cmd_if rate_cmd ();

	yaw_accumulator yaw_accumulator_inst (
		.us_clk        (us_clk),
		.resetn        (resetn),
		.start_signal  (start_signal),
		.yaw_target    (yaw_target),
		.yaw_actual    (yaw_actual),
		.heading_error (heading_error)
	);

	angle_controller angle_controller_inst (
		.us_clk, .resetn, .start_signal,
		.throttle_target, .yaw_target, .pitch_target, .roll_target,
		.heading_error, .pitch_actual, .roll_actual, .switch_a, .yaac_enable_n,
		.rate_cmd          (rate_cmd.source),
		.active_signal, .pitch_angle_error, .roll_angle_error, .yaw_angle_error
	);

	motor_mixer motor_mixer_inst (
		.us_clk, .resetn,
		.rate_cmd     (rate_cmd.sink),
		.motor_0, .motor_1, .motor_2, .motor_3, .motors_valid
	);

endmodule

// ==== test/attitude_tb.sv ====
`timescale 1ns/1ps

module attitude_tb import flight_pkg::*; ();

	localparam int WAIT_LIMIT = 40;

	logic                             us_clk;
	logic                             resetn;
	logic                             start_signal;
	logic [REC_VAL_BIT_WIDTH-1:0]     throttle_target, yaw_target, pitch_target, roll_target;
	logic signed [RATE_BIT_WIDTH-1:0] yaw_actual, pitch_actual, roll_actual;
	logic                             switch_a, yaac_enable_n;
	logic [RATE_BIT_WIDTH-1:0]        motor_0, motor_1, motor_2, motor_3;
	logic                             motors_valid, active_signal;
	logic signed [RATE_BIT_WIDTH-1:0] pitch_angle_error, roll_angle_error, yaw_angle_error;

	// reference model state
	int heading_ref, heading_err_ref;
	int exp_pitch_err, exp_roll_err, exp_yaw_err;
	int exp_motor [4];

	attitude_top attitude_top_inst (.*);

	always #50 us_clk = ~us_clk;

	function automatic int stick_to_angle(input int stick);
		return stick * 4 - MAPPING_SUBS;
	endfunction

	// back into -180..180 deg
	function automatic int fold_angle(input int angle);
		if (angle >= HEADING_HALF_TURN)
			return angle - 2 * HEADING_HALF_TURN;
		if (angle < -HEADING_HALF_TURN)
			return angle + 2 * HEADING_HALF_TURN;
		return angle;
	endfunction

	function automatic int limit_value(input int val, input int lo, input int hi);
		if (val > hi)
			return hi;
		if (val < lo)
			return lo;
		return val;
	endfunction

	// multiply, shift, then saturate to 16 bits
	function automatic int apply_gain(input int val, input int k, input int shift);
		return limit_value((val * k) >>> shift, -32767, 32767);
	endfunction

	function automatic int random_angle();
		return int'($urandom_range(5759, 0)) - HEADING_HALF_TURN;
	endfunction

	task automatic stop_with_failure();
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("Fail %s: expected %0d, actual %0d", name, expected, actual);
			stop_with_failure();
		end
	endtask

	// every start pulse moves the heading, even one the controller ignores
	task automatic accumulate_heading();
		int raw;
		raw = heading_ref + (stick_to_angle(yaw_target) >>> YAW_TICK_SHIFT);
		heading_ref = fold_angle(raw);
		heading_err_ref = fold_angle(heading_ref - yaw_actual);
	endtask

	task automatic predict_outputs();
		int mult, pitch, roll, yaw;
		int thr_rate, pitch_rate, roll_rate, yaw_rate;
		mult = switch_a ? 2 : 1;
		pitch = stick_to_angle(pitch_target) * mult - pitch_actual;
		// IMU roll enters with flipped sign
		roll = stick_to_angle(roll_target) * mult + roll_actual;
		yaw = yaac_enable_n ? stick_to_angle(yaw_target) : heading_err_ref;
		exp_pitch_err = limit_value(pitch, -32767, 32767);
		exp_roll_err = limit_value(roll, -32767, 32767);
		exp_yaw_err = limit_value(yaw, -32767, 32767);
		thr_rate = apply_gain(int'(throttle_target) * 16, THROTTLE_K_P, THROTTLE_K_P_SHIFT);
		thr_rate = limit_value(thr_rate, 0, THROTTLE_MAX);
		pitch_rate = apply_gain(pitch, PITCH_K_P, PITCH_K_P_SHIFT);
		pitch_rate = limit_value(pitch_rate, -AXIS_RATE_MAX, AXIS_RATE_MAX);
		roll_rate = apply_gain(roll, ROLL_K_P, ROLL_K_P_SHIFT);
		roll_rate = limit_value(roll_rate, -AXIS_RATE_MAX, AXIS_RATE_MAX);
		if (yaac_enable_n)
			yaw_rate = apply_gain(yaw, YAW_STICK_K_P, YAW_STICK_K_P_SHIFT);
		else
			yaw_rate = apply_gain(yaw, YAW_ACC_K_P, YAW_ACC_K_P_SHIFT);
		yaw_rate = limit_value(yaw_rate, -AXIS_RATE_MAX, AXIS_RATE_MAX);
		// X frame mix
		exp_motor[0] = limit_value(thr_rate + pitch_rate + roll_rate - yaw_rate, 0, MOTOR_MAX);
		exp_motor[1] = limit_value(thr_rate + pitch_rate - roll_rate + yaw_rate, 0, MOTOR_MAX);
		exp_motor[2] = limit_value(thr_rate - pitch_rate + roll_rate + yaw_rate, 0, MOTOR_MAX);
		exp_motor[3] = limit_value(thr_rate - pitch_rate - roll_rate - yaw_rate, 0, MOTOR_MAX);
	endtask

	task automatic check_outputs(input string name);
		check_value({name, " pitch_angle_error"}, exp_pitch_err, pitch_angle_error);
		check_value({name, " roll_angle_error"}, exp_roll_err, roll_angle_error);
		check_value({name, " yaw_angle_error"}, exp_yaw_err, yaw_angle_error);
		check_value({name, " motor_0"}, exp_motor[0], motor_0);
		check_value({name, " motor_1"}, exp_motor[1], motor_1);
		check_value({name, " motor_2"}, exp_motor[2], motor_2);
		check_value({name, " motor_3"}, exp_motor[3], motor_3);
	endtask

	task automatic apply_inputs(
		input int thr, input int yaw, input int pitch, input int roll,
		input int yaw_act, input int pitch_act, input int roll_act,
		input bit sw, input bit yaac_n
	);
		@(negedge us_clk);
		throttle_target = thr;
		yaw_target = yaw;
		pitch_target = pitch;
		roll_target = roll;
		yaw_actual = yaw_act;
		pitch_actual = pitch_act;
		roll_actual = roll_act;
		switch_a = sw;
		yaac_enable_n = yaac_n;
	endtask

	// one update, optionally with a second start while the controller is busy
	task automatic run_update(input string name, input bit inject_busy);
		int cycles;
		int first_active;
		bit busy_sent;
		@(negedge us_clk);
		start_signal = 1'b1;
		accumulate_heading();
		predict_outputs();
		@(negedge us_clk);
		start_signal = 1'b0;
		cycles = 0;
		first_active = -1;
		busy_sent = 1'b0;
		while (!motors_valid && cycles < WAIT_LIMIT) begin
			@(negedge us_clk);
			cycles++;
			start_signal = 1'b0;
			if (active_signal && first_active < 0)
				first_active = cycles;
			if (inject_busy && active_signal && !busy_sent) begin
				start_signal = 1'b1;
				busy_sent = 1'b1;
				accumulate_heading();
			end
		end
		if (!motors_valid) begin
			$display("Timeout: motors_valid never arrived during %s", name);
			stop_with_failure();
		end
		check_value({name, " active delay"}, 2, first_active);
		check_value({name, " latency"}, 6, cycles);
		check_outputs(name);
	endtask

	initial begin
		int thr;
		void'($urandom(32'h98b8_a02a));
		us_clk = 1'b0;
		resetn = 1'b0;
		start_signal = 1'b0;
		throttle_target = '0;
		yaw_target = 8'd125;
		pitch_target = 8'd125;
		roll_target = 8'd125;
		yaw_actual = '0;
		pitch_actual = '0;
		roll_actual = '0;
		switch_a = 1'b0;
		yaac_enable_n = 1'b1;
		heading_ref = 0;
		heading_err_ref = 0;
		repeat (16) @(negedge us_clk);
		resetn = 1'b1;
		@(negedge us_clk);

		// reset values, expectations still zero
		check_outputs("reset");
		check_value("reset active_signal", 0, active_signal);
		check_value("reset motors_valid", 0, motors_valid);

		// timing and a start while busy
		apply_inputs(100, 125, 125, 125, 0, 0, 0, 1'b0, 1'b1);
		run_update("timing", 1'b1);
		repeat (10) begin
			@(negedge us_clk);
			check_value("busy start active_signal", 0, active_signal);
			check_value("busy start motors_valid", 0, motors_valid);
		end

		// throttle only, last two hit the limit
		for (int i = 0; i < 8; i++) begin
			thr = (i < 6) ? int'($urandom_range(250, 0)) : 250 + (i - 6) * 5;
			apply_inputs(thr, 125, 125, 125, 0, 0, 0, $urandom_range(1, 0), 1'b1);
			run_update("throttle", 1'b0);
		end

		for (int i = 0; i < 24; i++) begin
			apply_inputs($urandom_range(200, 60), 125, $urandom_range(250, 0),
				$urandom_range(250, 0), 0, random_angle(), random_angle(),
				$urandom_range(1, 0), 1'b1);
			run_update("pitch roll", 1'b0);
		end
		// pitch rate pinned at the axis limit
		apply_inputs(250, 125, 250, 125, 0, -2880, 0, 1'b1, 1'b1);
		run_update("pitch limit", 1'b0);
		check_value("pitch limit motor_2", THROTTLE_MAX - AXIS_RATE_MAX, motor_2);
		apply_inputs(120, 125, 0, 250, 0, 2800, 2800, 1'b1, 1'b1);
		run_update("pitch roll limit", 1'b0);

		for (int i = 0; i < 10; i++) begin
			apply_inputs(150, $urandom_range(250, 0), 125, 125, random_angle(), 0, 0,
				1'b0, 1'b1);
			run_update("yaw stick", 1'b0);
		end

		// held stick walks the heading past +180 deg
		for (int i = 0; i < 100; i++) begin
			apply_inputs(150, 250, 125, 125, random_angle(), 0, 0, 1'b0, 1'b0);
			run_update("yaw accumulator", 1'b0);
		end
		for (int i = 0; i < 20; i++) begin
			apply_inputs(150, 0, 125, 125, random_angle(), 0, 0, 1'b0, 1'b0);
			run_update("yaw accumulator reverse", 1'b0);
		end

		apply_inputs(0, 125, 250, 125, 0, 0, 0, 1'b0, 1'b1);
		run_update("mixer clamp low", 1'b0);
		check_value("mixer clamp low motor_2", 0, motor_2);
		check_value("mixer clamp low motor_3", 0, motor_3);
		apply_inputs(250, 125, 250, 250, 0, 0, 0, 1'b1, 1'b1);
		run_update("mixer clamp high", 1'b0);
		check_value("mixer clamp high motor_0", MOTOR_MAX, motor_0);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== sim.f ====
verilog/flight_pkg.sv
verilog/rate_cmd_if.sv
verilog/yaw_accumulator.sv
verilog/angle_controller.sv
verilog/motor_mixer.sv
verilog/attitude_top.sv
test/attitude_tb.sv

// ==== Bender.yml ====
package:
  name: attitude_stage

sources:
  - verilog/flight_pkg.sv
  - verilog/rate_cmd_if.sv
  - verilog/yaw_accumulator.sv
  - verilog/angle_controller.sv
  - verilog/motor_mixer.sv
  - verilog/attitude_top.sv
  - target: test
    files:
      - test/attitude_tb.sv
